//--- source/periph_defs.svh
/*
 * periph_defs: address map, register offsets and source count
 */
`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

`define PERIPH_NUM_SRC 9

// region select, region 3 unmapped
`define REGION_GPIO  2'd0
`define REGION_TIMER 2'd1
`define REGION_PLIC  2'd2

// gpio register offsets
`define GPIO_DATA_IN     6'd0
`define GPIO_DATA_OUT    6'd1
`define GPIO_OE          6'd2
`define GPIO_INTR_ENABLE 6'd3
`define GPIO_INTR_STATE  6'd4

// timer register offsets
`define TMR_CTRL        6'd0
`define TMR_MTIME       6'd1
`define TMR_MTIMECMP    6'd2
`define TMR_INTR_ENABLE 6'd3
`define TMR_INTR_STATE  6'd4

// plic register offsets, priority of id n sits at PRIO_BASE + n
`define PLIC_PRIO_BASE 6'd0
`define PLIC_PENDING   6'd16
`define PLIC_ENABLE    6'd17
`define PLIC_THRESHOLD 6'd18
`define PLIC_CLAIM     6'd19

`endif

//--- source/periph_pkg.sv
/*
 * periph_pkg: vector types shared by the peripheral subsystem and its testbench
 */
`include "periph_defs.svh"

package periph_pkg;

  // word address, region in bits 7..6 and offset in bits 5..0
  typedef logic [7:0] addr_t;

  // register data word
  typedef logic [31:0] word_t;

  // one bit per gpio pin
  typedef logic [7:0] gpio_t;

  // one bit per interrupt source, bit 0 is id 1
  typedef logic [`PERIPH_NUM_SRC-1:0] src_vec_t;

  // source id, 0 means no request
  typedef logic [3:0] irq_id_t;

  // priority level, 0 never interrupts
  typedef logic [1:0] prio_t;

endpackage

//--- source/reg_bus_decode.sv
/*
 * reg_bus_decode: routes host strobes to gpio, timer and plic by region
 * and registers the read word of the addressed block
 */
`timescale 1ns/1ps
`include "periph_defs.svh"

module reg_bus_decode import periph_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       reg_we_i,
  input  logic       reg_re_i,
  input  addr_t      reg_addr_i,
  input  word_t      gpio_rdata_i,
  input  word_t      tmr_rdata_i,
  input  word_t      plic_rdata_i,
  output logic       gpio_we_o,
  output logic       gpio_re_o,
  output logic       tmr_we_o,
  output logic       tmr_re_o,
  output logic       plic_we_o,
  output logic       plic_re_o,
  output logic [5:0] reg_offset_o,
  output word_t      reg_rdata_o
);

  logic [1:0] region;
  word_t      rdata_sel;

  assign region       = reg_addr_i[7:6];
  assign reg_offset_o = reg_addr_i[5:0];

  // strobes only reach the block that owns the region
  assign gpio_we_o = reg_we_i && (region == `REGION_GPIO);
  assign gpio_re_o = reg_re_i && (region == `REGION_GPIO);
  assign tmr_we_o  = reg_we_i && (region == `REGION_TIMER);
  assign tmr_re_o  = reg_re_i && (region == `REGION_TIMER);
  assign plic_we_o = reg_we_i && (region == `REGION_PLIC);
  assign plic_re_o = reg_re_i && (region == `REGION_PLIC);

  always_comb begin
    case (region)
      `REGION_GPIO:  rdata_sel = gpio_rdata_i;
      `REGION_TIMER: rdata_sel = tmr_rdata_i;
      `REGION_PLIC:  rdata_sel = plic_rdata_i;
      default:       rdata_sel = '0;
    endcase
  end

  // read word holds until the next read
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      reg_rdata_o <= '0;
    end else if (reg_re_i) begin
      reg_rdata_o <= rdata_sel;
    end
  end

endmodule

//--- source/gpio_intr.sv
/*
 * gpio_intr: pin output and enable registers, synchronized inputs and
 * rising-edge interrupts with write-one-to-clear state
 */
`timescale 1ns/1ps
`include "periph_defs.svh"

module gpio_intr import periph_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       we_i,
  input  logic       re_i,
  input  logic [5:0] offset_i,
  input  word_t      wdata_i,
  input  gpio_t      gpio_i,
  output word_t      rdata_o,
  output gpio_t      gpio_o,
  output gpio_t      gpio_en_o,
  output gpio_t      intr_o
);

  gpio_t sync_q1;
  gpio_t sync_q2;
  gpio_t prev_q;
  gpio_t out_q;
  gpio_t oe_q;
  gpio_t ie_q;
  gpio_t state_q;
  gpio_t rise;
  gpio_t clr;
  word_t rdata;

  // two-flop synchronizer, then one more stage for edge detection
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
      prev_q  <= '0;
    end else begin
      sync_q1 <= gpio_i;
      sync_q2 <= sync_q1;
      prev_q  <= sync_q2;
    end
  end

  assign rise = sync_q2 & ~prev_q;
  assign clr  = (we_i && (offset_i == `GPIO_INTR_STATE)) ? wdata_i[7:0] : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_q   <= '0;
      oe_q    <= '0;
      ie_q    <= '0;
      state_q <= '0;
    end else begin
      if (we_i && (offset_i == `GPIO_DATA_OUT)) begin
        out_q <= wdata_i[7:0];
      end
      if (we_i && (offset_i == `GPIO_OE)) begin
        oe_q <= wdata_i[7:0];
      end
      if (we_i && (offset_i == `GPIO_INTR_ENABLE)) begin
        ie_q <= wdata_i[7:0];
      end
      // a new edge beats a clear in the same cycle
      state_q <= (state_q & ~clr) | rise;
    end
  end

  always_comb begin
    case (offset_i)
      `GPIO_DATA_IN:     rdata = word_t'(sync_q2);
      `GPIO_DATA_OUT:    rdata = word_t'(out_q);
      `GPIO_OE:          rdata = word_t'(oe_q);
      `GPIO_INTR_ENABLE: rdata = word_t'(ie_q);
      `GPIO_INTR_STATE:  rdata = word_t'(state_q);
      default:           rdata = '0;
    endcase
  end

  // read bus stays quiet outside a read
  assign rdata_o   = re_i ? rdata : '0;
  assign gpio_o    = out_q;
  assign gpio_en_o = oe_q;
  assign intr_o    = state_q & ie_q;

endmodule

//--- source/mtimer.sv
/*
 * mtimer: free-running machine timer with compare and sticky expiry interrupt
 */
`timescale 1ns/1ps
`include "periph_defs.svh"

module mtimer import periph_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       we_i,
  input  logic [5:0] offset_i,
  input  word_t      wdata_i,
  output word_t      rdata_o,
  output logic       intr_o
);

  logic  active_q;
  word_t mtime_q;
  word_t mtimecmp_q;
  logic  ie_q;
  logic  state_q;
  logic  expired;
  logic  clr;

  assign expired = active_q && (mtime_q >= mtimecmp_q);
  assign clr     = we_i && (offset_i == `TMR_INTR_STATE) && wdata_i[0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      active_q   <= 1'b0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      ie_q       <= 1'b0;
      state_q    <= 1'b0;
    end else begin
      if (we_i && (offset_i == `TMR_CTRL)) begin
        active_q <= wdata_i[0];
      end
      // a host write to mtime overrides the increment
      if (we_i && (offset_i == `TMR_MTIME)) begin
        mtime_q <= wdata_i;
      end else if (active_q) begin
        mtime_q <= mtime_q + 32'd1;
      end
      if (we_i && (offset_i == `TMR_MTIMECMP)) begin
        mtimecmp_q <= wdata_i;
      end
      if (we_i && (offset_i == `TMR_INTR_ENABLE)) begin
        ie_q <= wdata_i[0];
      end
      state_q <= (state_q && !clr) || expired;
    end
  end

  always_comb begin
    case (offset_i)
      `TMR_CTRL:        rdata_o = word_t'(active_q);
      `TMR_MTIME:       rdata_o = mtime_q;
      `TMR_MTIMECMP:    rdata_o = mtimecmp_q;
      `TMR_INTR_ENABLE: rdata_o = word_t'(ie_q);
      `TMR_INTR_STATE:  rdata_o = word_t'(state_q);
      default:          rdata_o = '0;
    endcase
  end

  assign intr_o = state_q && ie_q;

endmodule

//--- source/plic_lite.sv
/*
 * plic_lite: reduced interrupt controller with gateways, priorities,
 * threshold and claim/complete arbitration into a single request
 */
`timescale 1ns/1ps
`include "periph_defs.svh"

module plic_lite import periph_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       we_i,
  input  logic       re_i,
  input  logic [5:0] offset_i,
  input  word_t      wdata_i,
  input  src_vec_t   intr_src_i,
  output word_t      rdata_o,
  output logic       irq_o,
  output irq_id_t    irq_id_o
);

  prio_t    prio_q [`PERIPH_NUM_SRC];
  src_vec_t ie_q;
  src_vec_t pending_q;
  src_vec_t claimed_q;
  prio_t    threshold_q;
  irq_id_t  best_id;
  prio_t    best_prio;
  src_vec_t claim_mask;
  src_vec_t complete_mask;
  logic     claim_rd;
  logic     complete_wr;

  // strict compare keeps the lower id on a tie
  always_comb begin
    best_id   = '0;
    best_prio = threshold_q;
    for (int i = 0; i < `PERIPH_NUM_SRC; i++) begin
      if (pending_q[i] && ie_q[i] && (prio_q[i] > best_prio)) begin
        best_id   = irq_id_t'(i + 1);
        best_prio = prio_q[i];
      end
    end
  end

  assign claim_rd    = re_i && (offset_i == `PLIC_CLAIM);
  assign complete_wr = we_i && (offset_i == `PLIC_CLAIM);

  always_comb begin
    for (int i = 0; i < `PERIPH_NUM_SRC; i++) begin
      claim_mask[i]    = claim_rd && (best_id == irq_id_t'(i + 1));
      complete_mask[i] = complete_wr && (wdata_i[3:0] == irq_id_t'(i + 1));
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < `PERIPH_NUM_SRC; i++) begin
        prio_q[i] <= '0;
      end
      ie_q        <= '0;
      threshold_q <= '0;
      pending_q   <= '0;
      claimed_q   <= '0;
      irq_o       <= 1'b0;
      irq_id_o    <= '0;
    end else begin
      for (int i = 0; i < `PERIPH_NUM_SRC; i++) begin
        if (we_i && (offset_i == 6'(`PLIC_PRIO_BASE + i + 1))) begin
          prio_q[i] <= wdata_i[1:0];
        end
      end
      if (we_i && (offset_i == `PLIC_ENABLE)) begin
        ie_q <= wdata_i[`PERIPH_NUM_SRC-1:0];
      end
      if (we_i && (offset_i == `PLIC_THRESHOLD)) begin
        threshold_q <= wdata_i[1:0];
      end
      // gateway blocks a source while it is claimed
      pending_q <= (pending_q | (intr_src_i & ~claimed_q)) & ~claim_mask;
      claimed_q <= (claimed_q | claim_mask) & ~complete_mask;
      irq_o     <= (best_id != '0);
      irq_id_o  <= best_id;
    end
  end

  always_comb begin
    rdata_o = '0;
    case (offset_i)
      `PLIC_PENDING:   rdata_o = word_t'(pending_q);
      `PLIC_ENABLE:    rdata_o = word_t'(ie_q);
      `PLIC_THRESHOLD: rdata_o = word_t'(threshold_q);
      `PLIC_CLAIM:     rdata_o = word_t'(best_id);
      default: begin
        for (int i = 0; i < `PERIPH_NUM_SRC; i++) begin
          if (offset_i == 6'(`PLIC_PRIO_BASE + i + 1)) begin
            rdata_o = word_t'(prio_q[i]);
          end
        end
      end
    endcase
  end

endmodule

//--- source/periph_top.sv
/*
 * periph_top: gpio and timer peripherals behind a register decoder,
 * with their interrupts combined by the plic
 */
`timescale 1ns/1ps

module periph_top import periph_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    reg_we_i,
  input  logic    reg_re_i,
  input  addr_t   reg_addr_i,
  input  word_t   reg_wdata_i,
  input  gpio_t   gpio_i,
  output word_t   reg_rdata_o,
  output gpio_t   gpio_o,
  output gpio_t   gpio_en_o,
  output logic    irq_o,
  output irq_id_t irq_id_o
);

  logic       gpio_we;
  logic       gpio_re;
  logic       tmr_we;
  logic       plic_we;
  logic       plic_re;
  logic [5:0] reg_offset;
  word_t      gpio_rdata;
  word_t      tmr_rdata;
  word_t      plic_rdata;
  gpio_t      gpio_intr;
  logic       tmr_intr;
  src_vec_t   intr_src;

  reg_bus_decode u_decode (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .reg_we_i     (reg_we_i),
    .reg_re_i     (reg_re_i),
    .reg_addr_i   (reg_addr_i),
    .gpio_rdata_i (gpio_rdata),
    .tmr_rdata_i  (tmr_rdata),
    .plic_rdata_i (plic_rdata),
    .gpio_we_o    (gpio_we),
    .gpio_re_o    (gpio_re),
    .tmr_we_o     (tmr_we),
    .tmr_re_o     (),
    .plic_we_o    (plic_we),
    .plic_re_o    (plic_re),
    .reg_offset_o (reg_offset),
    .reg_rdata_o  (reg_rdata_o)
  );

  gpio_intr u_gpio (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .we_i      (gpio_we),
    .re_i      (gpio_re),
    .offset_i  (reg_offset),
    .wdata_i   (reg_wdata_i),
    .gpio_i    (gpio_i),
    .rdata_o   (gpio_rdata),
    .gpio_o    (gpio_o),
    .gpio_en_o (gpio_en_o),
    .intr_o    (gpio_intr)
  );

  mtimer u_timer (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .we_i     (tmr_we),
    .offset_i (reg_offset),
    .wdata_i  (reg_wdata_i),
    .rdata_o  (tmr_rdata),
    .intr_o   (tmr_intr)
  );

  // timer is id 9, gpio pins are ids 1 to 8
  assign intr_src = {tmr_intr, gpio_intr};

  plic_lite u_plic (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .we_i       (plic_we),
    .re_i       (plic_re),
    .offset_i   (reg_offset),
    .wdata_i    (reg_wdata_i),
    .intr_src_i (intr_src),
    .rdata_o    (plic_rdata),
    .irq_o      (irq_o),
    .irq_id_o   (irq_id_o)
  );

endmodule

//--- test/tb_clock.sv
/*
 * tb_clock: free-running testbench clock, 20 ns period
 */
`timescale 1ns/1ps

module tb_clock (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #10 clk_o = ~clk_o;

endmodule

//--- test/periph_props.sv
/*
 * periph_props: concurrent checks on the register port and interrupt
 * request of the peripheral top level
 */
`timescale 1ns/1ps

module periph_props import periph_pkg::*; (
  input logic    clk_i,
  input logic    rst_i,
  input logic    reg_we_i,
  input logic    reg_re_i,
  input logic    irq_i,
  input irq_id_t irq_id_i
);

  logic wr_seen_q;

  // set by the first host write after reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_seen_q <= 1'b0;
    end else if (reg_we_i) begin
      wr_seen_q <= 1'b1;
    end
  end

  quiet_after_reset: assert property (@(posedge clk_i) disable iff (rst_i)
    !wr_seen_q |-> !irq_i)
    else $error("irq raised before any register write");

  irq_has_id: assert property (@(posedge clk_i) disable iff (rst_i)
    irq_i |-> (irq_id_i != '0))
    else $error("irq high with source id zero");

  one_strobe: assert property (@(posedge clk_i) disable iff (rst_i)
    !(reg_we_i && reg_re_i))
    else $error("write and read strobes high together");

endmodule

//--- test/periph_tb.sv
/*
 * periph_tb: directed tests of the gpio, timer and plic register paths
 * and of interrupt arbitration through the top level
 */
`timescale 1ns/1ps
`include "periph_defs.svh"

module periph_tb import periph_pkg::*; ();

  // cycle budget per test for the watchdog
  localparam int RESET_CYCLES = 10;
  localparam int T1_CYCLES = 100;
  localparam int T2_CYCLES = 100;
  localparam int T3_CYCLES = 80;
  localparam int T4_CYCLES = 150;
  localparam int T5_CYCLES = 250;
  localparam int T6_CYCLES = 100;
  localparam int RUN_LIMIT = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES +
                             T4_CYCLES + T5_CYCLES + T6_CYCLES + 200;

  logic    clk;
  logic    rst;
  logic    reg_we;
  logic    reg_re;
  addr_t   reg_addr;
  word_t   reg_wdata;
  gpio_t   gpio_in;
  word_t   reg_rdata;
  gpio_t   gpio_out;
  gpio_t   gpio_en;
  logic    irq;
  irq_id_t irq_id;

  logic [31:0] lfsr_q;
  int tests_run = 0;
  int tests_failed = 0;
  int check_errs = 0;
  int test_errs = 0;

  // reference state of the interrupt controller
  prio_t    prio_m [1:`PERIPH_NUM_SRC];
  src_vec_t en_m;
  prio_t    thr_m;
  src_vec_t active_m;
  src_vec_t claimed_m;
  src_vec_t pend_m;

  tb_clock clock_gen (
    .clk_o (clk)
  );

  periph_top periph_top_i (
    .clk_i       (clk),
    .rst_i       (rst),
    .reg_we_i    (reg_we),
    .reg_re_i    (reg_re),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .gpio_i      (gpio_in),
    .reg_rdata_o (reg_rdata),
    .gpio_o      (gpio_out),
    .gpio_en_o   (gpio_en),
    .irq_o       (irq),
    .irq_id_o    (irq_id)
  );

  bind periph_top periph_props periph_props_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .reg_we_i (reg_we_i),
    .reg_re_i (reg_re_i),
    .irq_i    (irq_o),
    .irq_id_i (irq_id_o)
  );

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic next_random(input int nbits, output word_t val);
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val = {val[30:0], lfsr_q[0]};
    end
  endtask

  function automatic addr_t make_addr(input logic [1:0] region, input logic [5:0] offset);
    return {region, offset};
  endfunction

  // highest priority above threshold wins among pending enabled ids
  // the lower id wins a tie
  function automatic irq_id_t expected_winner(input src_vec_t pend);
    irq_id_t win;
    prio_t   top;
    win = '0;
    top = thr_m;
    for (int id = 1; id <= `PERIPH_NUM_SRC; id++) begin
      if (pend[id-1] && en_m[id-1] && (prio_m[id] > top)) begin
        win = irq_id_t'(id);
        top = prio_m[id];
      end
    end
    return win;
  endfunction

  task automatic check_value(input string name, input word_t got, input word_t exp);
    assert (got == exp) else begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("Check failed: %s", what);
      test_errs++;
    end
  endtask

  task automatic reg_write(input addr_t addr, input word_t data);
    @(negedge clk);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_we    = 1'b0;
  endtask

  // read data is registered at the edge after the strobe
  task automatic reg_read(input addr_t addr, output word_t data);
    @(negedge clk);
    reg_re   = 1'b1;
    reg_addr = addr;
    @(negedge clk);
    reg_re   = 1'b0;
    data     = reg_rdata;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    check_errs += test_errs;
    if (test_errs == 0) begin
      $display("[%0t] %s: ok", $time, name);
    end else begin
      tests_failed++;
      $display("[%0t] %s: %0d errors", $time, name, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic wait_timer_state(output logic seen);
    word_t rd;
    seen = 1'b0;
    for (int n = 0; (n < 40) && !seen; n++) begin
      reg_read(make_addr(`REGION_TIMER, `TMR_INTR_STATE), rd);
      seen = rd[0];
    end
  endtask

  task automatic reset_values();
    word_t rd;
    for (int off = 0; off < 5; off++) begin
      reg_read(make_addr(`REGION_GPIO, 6'(off)), rd);
      check_value($sformatf("gpio reg %0d", off), rd, 32'h0);
      reg_read(make_addr(`REGION_TIMER, 6'(off)), rd);
      check_value($sformatf("timer reg %0d", off), rd,
                  (6'(off) == `TMR_MTIMECMP) ? 32'hffff_ffff : 32'h0);
    end
    for (int id = 1; id <= `PERIPH_NUM_SRC; id++) begin
      reg_read(make_addr(`REGION_PLIC, `PLIC_PRIO_BASE + 6'(id)), rd);
      check_value($sformatf("plic priority %0d", id), rd, 32'h0);
    end
    for (int off = 16; off < 20; off++) begin
      reg_read(make_addr(`REGION_PLIC, 6'(off)), rd);
      check_value($sformatf("plic reg %0d", off), rd, 32'h0);
    end
    reg_read(make_addr(2'd3, 6'd0), rd);
    check_value("unmapped region", rd, 32'h0);
    check_value("gpio_o", word_t'(gpio_out), 32'h0);
    check_value("gpio_en_o", word_t'(gpio_en), 32'h0);
    check_value("irq_o", word_t'(irq), 32'h0);
    finish_test("reset values");
  endtask

  task automatic gpio_path();
    word_t val_out;
    word_t val_oe;
    word_t pins;
    word_t rd;
    for (int n = 0; n < 3; n++) begin
      next_random(8, val_out);
      next_random(8, val_oe);
      reg_write(make_addr(`REGION_GPIO, `GPIO_DATA_OUT), val_out);
      reg_write(make_addr(`REGION_GPIO, `GPIO_OE), val_oe);
      check_value("gpio_o", word_t'(gpio_out), val_out);
      check_value("gpio_en_o", word_t'(gpio_en), val_oe);
      next_random(8, pins);
      @(negedge clk);
      gpio_in = pins[7:0];
      repeat (3) @(negedge clk);
      reg_read(make_addr(`REGION_GPIO, `GPIO_DATA_IN), rd);
      check_value("gpio data_in", rd, pins);
    end
    finish_test("gpio path");
  endtask

  task automatic gpio_interrupts();
    word_t rise;
    word_t clr;
    word_t rd;
    @(negedge clk);
    gpio_in = '0;
    repeat (4) @(negedge clk);
    reg_write(make_addr(`REGION_GPIO, `GPIO_INTR_STATE), 32'hff);
    reg_read(make_addr(`REGION_GPIO, `GPIO_INTR_STATE), rd);
    check_value("gpio intr_state", rd, 32'h0);
    next_random(8, rise);
    @(negedge clk);
    gpio_in = rise[7:0];
    repeat (4) @(negedge clk);
    reg_read(make_addr(`REGION_GPIO, `GPIO_INTR_STATE), rd);
    check_value("gpio intr_state", rd, rise);
    // pins stay high, so no new edge refills the cleared bits
    next_random(8, clr);
    reg_write(make_addr(`REGION_GPIO, `GPIO_INTR_STATE), clr);
    reg_read(make_addr(`REGION_GPIO, `GPIO_INTR_STATE), rd);
    check_value("gpio intr_state", rd, rise & ~clr);
    finish_test("gpio interrupt state");
  endtask

  task automatic timer_expiry();
    logic  seen;
    word_t t1;
    word_t t2;
    word_t rd;
    reg_write(make_addr(`REGION_TIMER, `TMR_MTIME), 32'h0);
    reg_write(make_addr(`REGION_TIMER, `TMR_MTIMECMP), 32'd20);
    reg_write(make_addr(`REGION_TIMER, `TMR_CTRL), 32'h1);
    wait_timer_state(seen);
    check_true(seen, "timer state bit did not set within 40 reads");
    reg_read(make_addr(`REGION_TIMER, `TMR_MTIME), t1);
    reg_read(make_addr(`REGION_TIMER, `TMR_MTIME), t2);
    check_true(t2 > t1, "mtime did not advance between two reads");
    // move the compare out of reach first or expiry sets the bit again
    reg_write(make_addr(`REGION_TIMER, `TMR_MTIMECMP), 32'hffff_ffff);
    reg_write(make_addr(`REGION_TIMER, `TMR_INTR_STATE), 32'h1);
    repeat (4) @(negedge clk);
    reg_read(make_addr(`REGION_TIMER, `TMR_INTR_STATE), rd);
    check_value("timer intr_state", rd, 32'h0);
    reg_write(make_addr(`REGION_TIMER, `TMR_CTRL), 32'h0);
    finish_test("timer expiry");
  endtask

  task automatic plic_arbitration();
    irq_id_t exp_id;
    irq_id_t first_id;
    word_t   rd;
    logic    seen;
    int      idx;
    int      guard;
    prio_m = '{2'd1, 2'd3, 2'd2, 2'd0, 2'd3, 2'd1, 2'd2, 2'd0, 2'd3};
    en_m   = 9'h1ef;
    thr_m  = 2'd1;
    for (int id = 1; id <= `PERIPH_NUM_SRC; id++) begin
      reg_write(make_addr(`REGION_PLIC, `PLIC_PRIO_BASE + 6'(id)), word_t'(prio_m[id]));
    end
    reg_write(make_addr(`REGION_PLIC, `PLIC_ENABLE), word_t'(en_m));
    reg_write(make_addr(`REGION_PLIC, `PLIC_THRESHOLD), word_t'(thr_m));
    @(negedge clk);
    gpio_in = '0;
    repeat (4) @(negedge clk);
    reg_write(make_addr(`REGION_GPIO, `GPIO_INTR_STATE), 32'hff);
    reg_write(make_addr(`REGION_GPIO, `GPIO_INTR_ENABLE), 32'hff);
    reg_write(make_addr(`REGION_TIMER, `TMR_MTIME), 32'h0);
    reg_write(make_addr(`REGION_TIMER, `TMR_MTIMECMP), 32'd4);
    reg_write(make_addr(`REGION_TIMER, `TMR_INTR_ENABLE), 32'h1);
    reg_write(make_addr(`REGION_TIMER, `TMR_CTRL), 32'h1);
    @(negedge clk);
    gpio_in = 8'h57;
    wait_timer_state(seen);
    check_true(seen, "timer state bit did not set within 40 reads");
    active_m  = {1'b1, 8'h57};
    claimed_m = '0;
    pend_m    = active_m;
    repeat (5) @(negedge clk);
    exp_id   = expected_winner(pend_m);
    first_id = exp_id;
    guard    = 0;
    while ((exp_id != '0) && (guard < `PERIPH_NUM_SRC)) begin
      check_value("irq_o", word_t'(irq), 32'h1);
      check_value("irq_id_o", word_t'(irq_id), word_t'(exp_id));
      reg_read(make_addr(`REGION_PLIC, `PLIC_CLAIM), rd);
      check_value("plic claim", rd, word_t'(exp_id));
      idx = int'(exp_id) - 1;
      claimed_m[idx] = 1'b1;
      pend_m[idx]    = 1'b0;
      repeat (5) @(negedge clk);
      exp_id = expected_winner(pend_m);
      guard++;
    end
    check_value("irq_o", word_t'(irq), 32'h0);
    reg_read(make_addr(`REGION_PLIC, `PLIC_CLAIM), rd);
    check_value("plic claim", rd, 32'h0);
    // source is still high, so completing re-arms its gateway
    reg_write(make_addr(`REGION_PLIC, `PLIC_CLAIM), word_t'(first_id));
    claimed_m[int'(first_id) - 1] = 1'b0;
    pend_m = pend_m | (active_m & ~claimed_m);
    repeat (5) @(negedge clk);
    exp_id = expected_winner(pend_m);
    check_value("irq_o", word_t'(irq), 32'h1);
    check_value("irq_id_o", word_t'(irq_id), word_t'(exp_id));
    finish_test("plic arbitration");
  endtask

  task automatic threshold_masking();
    word_t rd;
    thr_m = 2'd3;
    reg_write(make_addr(`REGION_PLIC, `PLIC_THRESHOLD), word_t'(thr_m));
    for (int id = 1; id <= `PERIPH_NUM_SRC; id++) begin
      if (claimed_m[id-1]) begin
        reg_write(make_addr(`REGION_PLIC, `PLIC_CLAIM), word_t'(id));
      end
    end
    claimed_m = '0;
    pend_m    = pend_m | active_m;
    repeat (5) @(negedge clk);
    check_value("irq_o", word_t'(irq), 32'h0);
    check_value("irq_id_o", word_t'(irq_id), 32'h0);
    reg_read(make_addr(`REGION_PLIC, `PLIC_CLAIM), rd);
    check_value("plic claim", rd, 32'h0);
    reg_read(make_addr(`REGION_PLIC, `PLIC_PENDING), rd);
    check_value("plic pending", rd, word_t'(pend_m));
    finish_test("threshold masking");
  endtask

  initial begin : watchdog
    repeat (RUN_LIMIT) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", RUN_LIMIT);
    $display("Some tests failed");
    $finish;
  end

  initial begin : main
    lfsr_q    = 32'hb2f2_6478;
    rst       = 1'b1;
    reg_we    = 1'b0;
    reg_re    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    gpio_in   = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    reset_values();
    gpio_path();
    gpio_interrupts();
    timer_expiry();
    plic_arbitration();
    threshold_masking();
    $display("Summary: %0d tests run, %0d failed, %0d check errors",
             tests_run, tests_failed, check_errs);
    if (tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+source
source/periph_pkg.sv
source/reg_bus_decode.sv
source/gpio_intr.sv
source/mtimer.sv
source/plic_lite.sv
source/periph_top.sv
test/tb_clock.sv
test/periph_props.sv
test/periph_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = periph_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
